/* Makefile */
# frame joiner simulation with Verilator

SIM := obj_dir/frame_join_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module frame_join_tb -f files.f -o frame_join_sim

run: compile
	$(SIM) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "simulation did not complete"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* files.f */
hw/frame_join_pkg.sv
hw/join_port_select.sv
hw/join_control.sv
hw/join_skid_buffer.sv
hw/frame_join_top.sv
tb/frame_join_assertions.sv
tb/frame_join_tb.sv

/* hw/frame_join_pkg.sv */
// ------------------------------
// frame joiner shared types
// byte, port index, stream beat
// and join FSM state encodings
// ------------------------------

package frame_join_pkg;

    // fixed port count of the joiner
    localparam int NUM_PORTS = 4;

    // one byte of stream payload
    typedef logic [7:0] byte_t;

    // input port index, 0 to 3 in join order
    typedef logic [1:0] port_sel_t;

    // one stream beat, 10 bits
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } beat_t;

    // join control FSM
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_tag      = 2'd1,
        st_transfer = 2'd2
    } join_state_t;

endpackage

/* hw/frame_join_top.sv */
// ------------------------------
// four port frame joiner
// optional tag header, then one
// frame from each input in order,
// through a two entry skid buffer
// ------------------------------

`timescale 1ns/100ps

module frame_join_top #(
    parameter int TAG_ENABLE = 1,
    parameter int TAG_WIDTH  = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,

    // input streams
    input  frame_join_pkg::beat_t                   in_beat [frame_join_pkg::NUM_PORTS],
    input  logic [frame_join_pkg::NUM_PORTS-1:0]    in_valid,
    output logic [frame_join_pkg::NUM_PORTS-1:0]    in_ready,

    // joined output stream
    output frame_join_pkg::beat_t                   out_beat,
    output logic                                    out_valid,
    input  logic                                    out_ready,

    // configuration and status
    input  logic [TAG_WIDTH-1:0]                    tag,
    output logic                                    busy
);

    // selector to control
    frame_join_pkg::beat_t sel_beat;
    logic                  sel_valid;
    logic                  sel_ready;
    logic                  sel_done;

    // control to skid buffer
    frame_join_pkg::beat_t ctl_beat;
    logic                  ctl_valid;
    logic                  ctl_ready;

    join_port_select u_port_select (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .sel_beat  (sel_beat),
        .sel_valid (sel_valid),
        .sel_ready (sel_ready),
        .sel_done  (sel_done)
    );

    // a frame only ever starts from port 0
    join_control #(
        .TAG_ENABLE (TAG_ENABLE),
        .TAG_WIDTH  (TAG_WIDTH)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .start_valid (in_valid[0]),
        .tag         (tag),
        .sel_beat    (sel_beat),
        .sel_valid   (sel_valid),
        .sel_ready   (sel_ready),
        .sel_done    (sel_done),
        .ctl_beat    (ctl_beat),
        .ctl_valid   (ctl_valid),
        .ctl_ready   (ctl_ready),
        .busy        (busy)
    );

    join_skid_buffer u_skid_buffer (
        .clk       (clk),
        .rst       (rst),
        .ctl_beat  (ctl_beat),
        .ctl_valid (ctl_valid),
        .ctl_ready (ctl_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* hw/join_control.sv */
// ------------------------------
// join control FSM
// sends the tag bytes msb first,
// forwards the selected frames and
// closes with last and OR'd user
// ------------------------------

`timescale 1ns/100ps

module join_control #(
    parameter int TAG_ENABLE = 1,
    parameter int TAG_WIDTH  = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  start_valid,
    input  logic [TAG_WIDTH-1:0]  tag,

    // selected input stream
    input  frame_join_pkg::beat_t sel_beat,
    input  logic                  sel_valid,
    output logic                  sel_ready,
    input  logic                  sel_done,

    // towards the skid buffer
    output frame_join_pkg::beat_t ctl_beat,
    output logic                  ctl_valid,
    input  logic                  ctl_ready,

    output logic                  busy
);

    localparam int TAG_BYTES = (TAG_WIDTH + 7) / 8;
    localparam int TAG_PAD_W = TAG_BYTES * 8;
    localparam int PTR_W     = (TAG_BYTES > 1) ? $clog2(TAG_BYTES) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // pointer counts down, so the first byte sent is the top one
    localparam ptr_t PTR_FIRST = ptr_t'(TAG_BYTES - 1);

    frame_join_pkg::join_state_t state;
    frame_join_pkg::join_state_t state_next;
    ptr_t                        ptr;
    ptr_t                        ptr_next;
    logic                        user_acc;
    logic                        user_acc_next;
    logic [TAG_PAD_W-1:0]        tag_pad;
    frame_join_pkg::byte_t       tag_byte;
    logic                        sel_xfer;

    // a partial top byte is zero filled
    assign tag_pad  = TAG_PAD_W'(tag);
    assign tag_byte = tag_pad[ptr*8 +: 8];

    assign sel_xfer = sel_valid && sel_ready;

    always_comb begin
        state_next    = state;
        ptr_next      = ptr;
        user_acc_next = user_acc;
        sel_ready     = 1'b0;
        ctl_valid     = 1'b0;
        ctl_beat      = '0;

        case (state)
            frame_join_pkg::st_idle: begin
                ptr_next      = PTR_FIRST;
                user_acc_next = 1'b0;
                if (start_valid) begin
                    if (TAG_ENABLE != 0) begin
                        state_next = frame_join_pkg::st_tag;
                    end else begin
                        state_next = frame_join_pkg::st_transfer;
                    end
                end
            end

            frame_join_pkg::st_tag: begin
                // no input is accepted while the tag goes out
                ctl_valid     = 1'b1;
                ctl_beat.data = tag_byte;
                if (ctl_ready) begin
                    if (ptr == '0) begin
                        state_next = frame_join_pkg::st_transfer;
                    end else begin
                        ptr_next = ptr - 1'b1;
                    end
                end
            end

            frame_join_pkg::st_transfer: begin
                sel_ready     = ctl_ready;
                ctl_valid     = sel_valid;
                ctl_beat.data = sel_beat.data;

                // inner frame ends are hidden, only the port 3 end closes
                ctl_beat.last = sel_done;
                ctl_beat.user = sel_done && (user_acc || sel_beat.user);

                if (sel_xfer && sel_beat.last) begin
                    user_acc_next = user_acc | sel_beat.user;
                end
                if (sel_done) begin
                    state_next = frame_join_pkg::st_idle;
                end
            end

            default: begin
                state_next = frame_join_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= frame_join_pkg::st_idle;
            ptr      <= PTR_FIRST;
            user_acc <= 1'b0;
        end else begin
            state    <= state_next;
            ptr      <= ptr_next;
            user_acc <= user_acc_next;
        end
    end

    // high from the cycle after start until the cycle after the final beat
    assign busy = (state != frame_join_pkg::st_idle);

endmodule

/* hw/join_port_select.sv */
// ------------------------------
// input port selector
// routes the current port to the
// join control, steps to the next
// port after each last beat
// ------------------------------

`timescale 1ns/100ps

module join_port_select (
    input  logic                                    clk,
    input  logic                                    rst,

    input  frame_join_pkg::beat_t                   in_beat [frame_join_pkg::NUM_PORTS],
    input  logic [frame_join_pkg::NUM_PORTS-1:0]    in_valid,
    output logic [frame_join_pkg::NUM_PORTS-1:0]    in_ready,

    output frame_join_pkg::beat_t                   sel_beat,
    output logic                                    sel_valid,
    input  logic                                    sel_ready,
    output logic                                    sel_done
);

    localparam frame_join_pkg::port_sel_t LAST_PORT =
        frame_join_pkg::port_sel_t'(frame_join_pkg::NUM_PORTS - 1);

    frame_join_pkg::port_sel_t port;
    logic                      last_xfer;

    // beat and valid of the current port
    assign sel_beat  = in_beat[port];
    assign sel_valid = in_valid[port];

    // only the current port sees ready
    always_comb begin
        in_ready       = '0;
        in_ready[port] = sel_ready;
    end

    assign last_xfer = sel_valid && sel_ready && sel_beat.last;

    // frame end of the whole join, same cycle as the transfer
    assign sel_done = last_xfer && (port == LAST_PORT);

    always_ff @(posedge clk) begin
        if (rst) begin
            port <= '0;
        end else if (last_xfer) begin
            if (port == LAST_PORT) begin
                port <= '0;
            end else begin
                port <= port + 1'b1;
            end
        end
    end

endmodule

/* hw/join_skid_buffer.sv */
// ------------------------------
// output skid buffer
// output register plus one temp
// entry, registered upstream ready
// ------------------------------

`timescale 1ns/100ps

module join_skid_buffer (
    input  logic                  clk,
    input  logic                  rst,

    input  frame_join_pkg::beat_t ctl_beat,
    input  logic                  ctl_valid,
    output logic                  ctl_ready,

    output frame_join_pkg::beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    frame_join_pkg::beat_t temp_beat;
    logic                  temp_empty;
    logic                  accept;
    logic                  out_load;

    // upstream only sees whether the temp entry is free
    assign ctl_ready = temp_empty;
    assign accept    = ctl_valid && temp_empty;

    // output register may take a new beat this cycle
    assign out_load  = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_empty <= 1'b1;
        end else if (out_load) begin
            if (!temp_empty) begin
                out_valid  <= 1'b1;
                temp_empty <= 1'b1;
            end else begin
                out_valid <= accept;
            end
        end else if (accept) begin
            // stalled with a valid output, park the beat
            temp_empty <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            if (!temp_empty) begin
                out_beat <= temp_beat;
            end else if (accept) begin
                out_beat <= ctl_beat;
            end
        end else if (accept) begin
            temp_beat <= ctl_beat;
        end
    end

endmodule

/* tb/frame_join_assertions.sv */
// ------------------------------
// frame joiner protocol checks
// handshake holds, ready routing
// and reset state, bound into
// the top level
// ------------------------------

`timescale 1ns/100ps

module frame_join_assertions (
    input logic                                 clk,
    input logic                                 rst,
    input logic [frame_join_pkg::NUM_PORTS-1:0] in_ready,
    input frame_join_pkg::beat_t                out_beat,
    input logic                                 out_valid,
    input logic                                 out_ready,
    input frame_join_pkg::beat_t                ctl_beat,
    input logic                                 ctl_valid,
    input logic                                 ctl_ready,
    input logic                                 busy
);

    int unsigned fail_count = 0;

    // at most one input port sees ready
    in_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(in_ready))
    else begin
        $error("more than one in_ready high: %h", in_ready);
        fail_count++;
    end

    // a stalled output beat stays put
    out_hold: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) |-> (out_valid && out_beat == $past(out_beat)))
    else begin
        $error("out_beat changed or out_valid dropped while stalled");
        fail_count++;
    end

    // control keeps its byte while the buffer is full
    ctl_hold: assert property (@(posedge clk) disable iff (rst)
        $past(ctl_valid && !ctl_ready) |->
            (ctl_valid && ctl_beat.data == $past(ctl_beat.data)))
    else begin
        $error("ctl_beat data changed while ctl_ready was low");
        fail_count++;
    end

    // idle control accepts nothing
    idle_no_ready: assert property (@(posedge clk) disable iff (rst)
        !busy |-> (in_ready == '0))
    else begin
        $error("in_ready high while not busy: %h", in_ready);
        fail_count++;
    end

    // an accepted beat reaches the output one cycle later unless stalled
    pass_through: assert property (@(posedge clk) disable iff (rst)
        (ctl_valid && ctl_ready && (out_ready || !out_valid)) |=>
            (out_valid && out_beat == $past(ctl_beat)))
    else begin
        $error("accepted beat did not reach the output on the next cycle");
        fail_count++;
    end

    reset_state: assert property (@(posedge clk)
        $past(rst) |-> (!out_valid && !busy && in_ready == '0 && ctl_ready))
    else begin
        $error("state after reset is wrong");
        fail_count++;
    end

endmodule

/* tb/frame_join_tb.sv */
// ------------------------------
// frame joiner testbench
// table of joined frames with LCG
// data, input gaps and output
// stalls, checked beat by beat
// ------------------------------

`timescale 1ns/100ps

module frame_join_tb;

    localparam int TAG_ENABLE   = 1;
    localparam int TAG_WIDTH    = 16;
    localparam int TAG_BYTES    = TAG_WIDTH / 8;
    localparam int PORTS        = frame_join_pkg::NUM_PORTS;
    localparam int MAX_LEN      = 6;
    localparam int ROW_TIMEOUT  = 500;
    localparam int IDLE_TIMEOUT = 10;

    // one joined frame per row
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [3:0][2:0]      lens;
        // bit p belongs to port p
        logic [3:0]           users;
        logic                 gaps;
        logic                 stalls;
    } case_row_t;

    logic                  clk;
    logic                  rst;
    frame_join_pkg::beat_t in_beat [PORTS];
    logic [PORTS-1:0]      in_valid;
    logic [PORTS-1:0]      in_ready;
    frame_join_pkg::beat_t out_beat;
    logic                  out_valid;
    logic                  out_ready;
    logic [TAG_WIDTH-1:0]  tag;
    logic                  busy;

    case_row_t             cases [$];
    frame_join_pkg::beat_t expected [$];
    frame_join_pkg::byte_t frame_data [PORTS][MAX_LEN];
    int                    sent [PORTS];
    logic [PORTS-1:0]      taken;
    logic [31:0]           lcg_state;
    int                    errors;
    int                    checks;
    int                    timeouts;
    int                    total;
    logic                  aborted;

    frame_join_top #(
        .TAG_ENABLE (TAG_ENABLE),
        .TAG_WIDTH  (TAG_WIDTH)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .tag       (tag),
        .busy      (busy)
    );

    bind frame_join_top frame_join_assertions u_assertions (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .ctl_beat  (ctl_beat),
        .ctl_valid (ctl_valid),
        .ctl_ready (ctl_ready),
        .busy      (busy)
    );

    always #2 clk = ~clk;

    // next LCG value from the upper half of the state
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic add_case(input logic [TAG_WIDTH-1:0] row_tag, input int len0,
                            input int len1, input int len2, input int len3,
                            input logic [3:0] row_users, input logic row_gaps,
                            input logic row_stalls);
        case_row_t row;
        row.tag     = row_tag;
        row.lens[0] = 3'(len0);
        row.lens[1] = 3'(len1);
        row.lens[2] = 3'(len2);
        row.lens[3] = 3'(len3);
        row.users   = row_users;
        row.gaps    = row_gaps;
        row.stalls  = row_stalls;
        cases.push_back(row);
    endtask

    // draws the frame bytes and builds the joined frame we expect
    task automatic prepare_row(input case_row_t row);
        frame_join_pkg::beat_t beat;
        logic [15:0]           r;
        expected.delete();
        beat = '0;
        if (TAG_ENABLE != 0) begin
            for (int b = TAG_BYTES - 1; b >= 0; b--) begin
                beat.data = row.tag[b*8 +: 8];
                expected.push_back(beat);
            end
        end
        for (int p = 0; p < PORTS; p++) begin
            sent[p] = 0;
            for (int i = 0; i < int'(row.lens[p]); i++) begin
                r = next_rand();
                frame_data[p][i] = r[7:0];
                beat.data = r[7:0];
                expected.push_back(beat);
            end
        end
        // only the closing byte carries last and the OR of the user bits
        beat = expected.pop_back();
        beat.last = 1'b1;
        beat.user = |row.users;
        expected.push_back(beat);
        taken = '0;
    endtask

    function automatic frame_join_pkg::beat_t input_beat(input case_row_t row, input int p);
        frame_join_pkg::beat_t beat;
        beat.data = frame_data[p][sent[p]];
        beat.last = (sent[p] == int'(row.lens[p]) - 1);
        beat.user = beat.last && row.users[p];
        return beat;
    endfunction

    task automatic drive_inputs(input case_row_t row);
        logic [15:0] r;
        for (int p = 0; p < PORTS; p++) begin
            // a beat taken at the last rising edge leaves the port
            if (taken[p]) begin
                in_valid[p] = 1'b0;
                taken[p]    = 1'b0;
            end
            if (!in_valid[p] && sent[p] < int'(row.lens[p])) begin
                r = next_rand();
                if (!row.gaps || r[0]) begin
                    in_beat[p]  = input_beat(row, p);
                    in_valid[p] = 1'b1;
                end
            end
        end
        if (row.stalls) begin
            r = next_rand();
            out_ready = r[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic check_beat(input int row_idx, input frame_join_pkg::beat_t want);
        checks++;
        assert (out_beat.data == want.data) else begin
            errors++;
            $display("[ERROR] row %0d out_beat.data: got %h expected %h",
                     row_idx, out_beat.data, want.data);
        end
        assert (out_beat.last == want.last) else begin
            errors++;
            $display("[ERROR] row %0d out_beat.last: got %h expected %h",
                     row_idx, out_beat.last, want.last);
        end
        assert (out_beat.user == want.user) else begin
            errors++;
            $display("[ERROR] row %0d out_beat.user: got %h expected %h",
                     row_idx, out_beat.user, want.user);
        end
    endtask

    task automatic run_row(input case_row_t row, input int row_idx);
        frame_join_pkg::beat_t want;
        logic                  started;
        logic                  closed;
        int                    cycles;
        started = 1'b0;
        closed  = 1'b0;
        cycles  = 0;
        prepare_row(row);
        while (expected.size() > 0 && cycles < ROW_TIMEOUT) begin
            @(negedge clk);
            if (cycles == 0) begin
                tag = row.tag;
            end
            drive_inputs(row);
            cycles++;
            #1;
            // busy follows the start on port 0 and the port 3 frame end
            assert (busy == (started && !closed)) else begin
                errors++;
                $display("[ERROR] row %0d cycle %0d busy: got %h expected %h",
                         row_idx, cycles, busy, started && !closed);
            end
            for (int p = 0; p < PORTS; p++) begin
                if (in_valid[p] && in_ready[p]) begin
                    taken[p] = 1'b1;
                    if (p == PORTS - 1 && in_beat[p].last) begin
                        closed = 1'b1;
                    end
                    sent[p]++;
                end
            end
            if (in_valid[0]) begin
                started = 1'b1;
            end
            if (out_valid && out_ready) begin
                want = expected.pop_front();
                check_beat(row_idx, want);
            end
        end
        if (expected.size() > 0) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout in row %0d: %0d output beats never arrived",
                     row_idx, expected.size());
        end
    endtask

    task automatic wait_idle(input int row_idx);
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout after row %0d: busy never went low", row_idx);
        end
    endtask

    // nothing may start or come out, with or without valid on ports 1 to 3
    task automatic check_idle(input int n, input logic side_valid);
        logic [15:0] r;
        for (int p = 1; p < PORTS; p++) begin
            r = next_rand();
            in_beat[p].data = r[7:0];
            in_beat[p].last = r[8];
            in_beat[p].user = r[9];
        end
        for (int c = 0; c < n; c++) begin
            @(negedge clk);
            out_ready = 1'b1;
            for (int p = 1; p < PORTS; p++) begin
                in_valid[p] = side_valid;
            end
            #1;
            assert (!busy && !out_valid && in_ready == '0) else begin
                errors++;
                $display("[ERROR] idle cycle %0d busy %h out_valid %h in_ready %h, all expected 0",
                         c, busy, out_valid, in_ready);
            end
        end
        @(negedge clk);
        in_valid = '0;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = '0;
        out_ready = 1'b0;
        tag       = '0;
        for (int p = 0; p < PORTS; p++) begin
            in_beat[p] = '0;
        end
        lcg_state = 32'h3161_2e90;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        aborted   = 1'b0;
        taken     = '0;

        // tag, lengths of ports 0..3, user bits (port 3 on the left), gaps, stalls
        add_case(16'hA55A, 1, 1, 1, 1, 4'b0000, 1'b0, 1'b0);
        add_case(16'h1234, 3, 2, 4, 1, 4'b0001, 1'b0, 1'b0);
        add_case(16'hBEEF, 6, 6, 6, 6, 4'b1000, 1'b0, 1'b1);
        add_case(16'h0F0F, 2, 5, 1, 3, 4'b0110, 1'b1, 1'b0);
        add_case(16'hFFFF, 4, 1, 6, 2, 4'b1111, 1'b1, 1'b1);
        add_case(16'h0000, 5, 3, 2, 6, 4'b0100, 1'b0, 1'b1);
        add_case(16'hC3A1, 1, 6, 1, 6, 4'b0000, 1'b1, 1'b1);
        add_case(16'h7E81, 6, 2, 3, 5, 4'b1010, 1'b1, 1'b1);

        repeat (3) @(negedge clk);
        rst = 1'b0;

        check_idle(6, 1'b0);
        check_idle(6, 1'b1);

        // rows run back to back without a reset in between
        for (int i = 0; i < cases.size() && !aborted; i++) begin
            run_row(cases[i], i);
            if (!aborted) begin
                wait_idle(i);
            end
        end
        if (!aborted) begin
            check_idle(4, 1'b0);
        end

        total = errors + timeouts + int'(UUT.u_assertions.fail_count);
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, UUT.u_assertions.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
